/* src.f */
cop_pkg.sv
cop_op_if.sv
cop_issue_decoder.sv
cop_op_fifo.sv
cop_exec_unit.sv
cop_subsystem.sv
tb_cop_subsystem.sv

/* Makefile */
TOP = tb_cop_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --top-module cop_subsystem -f src.f

clean:
	rm -rf obj_dir

/* tb_cop_subsystem.sv */
`timescale 1ns/1ns

module tb_cop_subsystem;

  localparam int unsigned FIFO_DEPTH = 4;
  // Rejects, single-cycle boundary and random, multiply boundary, mixed, capacity
  localparam int unsigned N_INSTR = 4 + 150 + 60 + 25 + 80 + FIFO_DEPTH + 1;
  localparam logic [6:0] CUSTOM0 = 7'b0001011;

  logic                clk_i;
  logic                rst_n_i;
  logic                x_issue_valid_i;
  logic                x_issue_ready_o;
  cop_pkg::xif_instr_t x_issue_instr_i;
  cop_pkg::xif_data_t  x_issue_rs1_i;
  cop_pkg::xif_data_t  x_issue_rs2_i;
  cop_pkg::xif_id_t    x_issue_id_i;
  logic                x_issue_accept_o;
  logic                x_result_valid_o;
  logic                x_result_ready_i;
  cop_pkg::xif_id_t    x_result_id_o;
  cop_pkg::xif_reg_t   x_result_rd_o;
  cop_pkg::xif_data_t  x_result_data_o;

  integer      seed;
  int unsigned rdy_mode;  // 0 always ready, 1 random, 2 held low
  int unsigned mismatch_cnt;
  int unsigned other_cnt;

  // Expected results in issue order
  cop_pkg::xif_id_t   exp_id_q[$];
  cop_pkg::xif_reg_t  exp_rd_q[$];
  cop_pkg::xif_data_t exp_data_q[$];
  cop_pkg::xif_id_t   exp_id;
  cop_pkg::xif_reg_t  exp_rd;
  cop_pkg::xif_data_t exp_data;

  // Result seen in the previous cycle while stalled
  logic               hold_valid;
  cop_pkg::xif_id_t   held_id;
  cop_pkg::xif_reg_t  held_rd;
  cop_pkg::xif_data_t held_data;

  cop_pkg::xif_data_t bnd [5];

  cop_subsystem #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .x_issue_valid_i (x_issue_valid_i),
    .x_issue_ready_o (x_issue_ready_o),
    .x_issue_instr_i (x_issue_instr_i),
    .x_issue_rs1_i   (x_issue_rs1_i),
    .x_issue_rs2_i   (x_issue_rs2_i),
    .x_issue_id_i    (x_issue_id_i),
    .x_issue_accept_o(x_issue_accept_o),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_id_o   (x_result_id_o),
    .x_result_rd_o   (x_result_rd_o),
    .x_result_data_o (x_result_data_o)
  );

  always #20 clk_i = ~clk_i;

  // Expected acceptance, destination and value of one instruction
  function automatic void expected_result(input cop_pkg::xif_instr_t instr,
                                          input cop_pkg::xif_data_t a,
                                          input cop_pkg::xif_data_t b,
                                          output logic acc,
                                          output cop_pkg::xif_reg_t rd,
                                          output cop_pkg::xif_data_t data);
    acc = (instr[6:0] == CUSTOM0) && (instr[14:12] != 3'b111);
    rd  = instr[11:7];
    case (instr[14:12])
      3'd0:    data = a + b;
      3'd1:    data = a - b;
      3'd2:    data = a ^ b;
      3'd3:    data = a & b;
      3'd4:    data = ($signed(a) < $signed(b)) ? a : b;
      3'd5:    data = ($signed(a) > $signed(b)) ? a : b;
      3'd6:    data = a * b;
      default: data = '0;
    endcase
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_id(input string name, input cop_pkg::xif_id_t got,
                          input cop_pkg::xif_id_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_rd(input string name, input cop_pkg::xif_reg_t got,
                          input cop_pkg::xif_reg_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_data(input string name, input cop_pkg::xif_data_t got,
                            input cop_pkg::xif_data_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Hold one instruction on the issue port until the handshake
  task automatic issue_instr(input logic [6:0] opcode, input logic [2:0] funct3,
                             input cop_pkg::xif_data_t a, input cop_pkg::xif_data_t b);
    cop_pkg::xif_instr_t instr;
    logic                acc;
    cop_pkg::xif_reg_t   rd;
    cop_pkg::xif_data_t  data;
    instr = {7'h00, 5'd2, 5'd1, funct3, cop_pkg::xif_reg_t'($random(seed)), opcode};
    @(negedge clk_i);
    x_issue_valid_i = 1'b1;
    x_issue_instr_i = instr;
    x_issue_rs1_i   = a;
    x_issue_rs2_i   = b;
    x_issue_id_i    = cop_pkg::xif_id_t'($random(seed));
    expected_result(instr, a, b, acc, rd, data);
    do begin
      @(posedge clk_i);
    end while (!x_issue_ready_o);
    check_flag("x_issue_accept_o", x_issue_accept_o, acc);
    if (acc) begin
      exp_id_q.push_back(x_issue_id_i);
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(data);
    end
    @(negedge clk_i);
    x_issue_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    for (int i = 0; i < 400 && exp_id_q.size() != 0; i++) begin
      @(posedge clk_i);
    end
  endtask

  always @(negedge clk_i) begin
    if (rdy_mode == 1) begin
      x_result_ready_i = ($random(seed) & 3) != 0;
    end else begin
      x_result_ready_i = (rdy_mode == 0);
    end
  end

  // Result monitor, also checks that a stalled result holds still
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (hold_valid) begin
        if (!x_result_valid_o) begin
          other_cnt++;
          $display("Result valid dropped without a handshake at %0t", $time);
        end
        check_id("x_result_id_o", x_result_id_o, held_id);
        check_rd("x_result_rd_o", x_result_rd_o, held_rd);
        check_data("x_result_data_o", x_result_data_o, held_data);
      end
      if (x_result_valid_o && x_result_ready_i) begin
        if (exp_id_q.size() == 0) begin
          other_cnt++;
          $display("Result with id 0x%h arrived with no instruction outstanding at %0t",
                   x_result_id_o, $time);
        end else begin
          exp_id   = exp_id_q.pop_front();
          exp_rd   = exp_rd_q.pop_front();
          exp_data = exp_data_q.pop_front();
          check_id("x_result_id_o", x_result_id_o, exp_id);
          check_rd("x_result_rd_o", x_result_rd_o, exp_rd);
          check_data("x_result_data_o", x_result_data_o, exp_data);
        end
      end
      hold_valid = x_result_valid_o && !x_result_ready_i;
      held_id    = x_result_id_o;
      held_rd    = x_result_rd_o;
      held_data  = x_result_data_o;
    end
  end

  initial begin
    #(N_INSTR * (cop_pkg::MUL_STEPS + 40) * 40);
    $display("Watchdog expired before the tests completed");
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int unsigned f3;
    seed             = 32'hcd1d_b84e;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    x_issue_valid_i  = 1'b0;
    x_issue_instr_i  = '0;
    x_issue_rs1_i    = '0;
    x_issue_rs2_i    = '0;
    x_issue_id_i     = '0;
    x_result_ready_i = 1'b1;
    rdy_mode         = 0;
    mismatch_cnt     = 0;
    other_cnt        = 0;
    hold_valid       = 1'b0;
    bnd = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    check_flag("x_result_valid_o", x_result_valid_o, 1'b0);
    check_flag("x_issue_ready_o", x_issue_ready_o, 1'b1);

    // Foreign opcodes and the unused funct3
    issue_instr(7'b0110011, 3'd0, 32'h5, 32'h6);
    issue_instr(7'b0101011, 3'd2, 32'h7, 32'h8);
    issue_instr(CUSTOM0, 3'b111, 32'h9, 32'ha);
    issue_instr(7'b0001010, 3'd6, 32'hb, 32'hc);

    for (int op = 0; op < 6; op++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_instr(CUSTOM0, 3'(op), bnd[i], bnd[j]);
        end
      end
      repeat (10) issue_instr(CUSTOM0, 3'(op), $random(seed), $random(seed));
    end
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        issue_instr(CUSTOM0, 3'd6, bnd[i], bnd[j]);
      end
    end

    // Mixed operations under random back-pressure
    rdy_mode = 1;
    repeat (80) begin
      f3 = $unsigned($random(seed)) % 7;
      issue_instr(CUSTOM0, 3'(f3), $random(seed), $random(seed));
    end
    rdy_mode = 0;
    wait_drain();

    // Buffer plus execution unit fill up with result ready low
    rdy_mode = 2;
    repeat (FIFO_DEPTH + 1) issue_instr(CUSTOM0, 3'd0, $random(seed), $random(seed));
    @(posedge clk_i);
    check_flag("x_issue_ready_o", x_issue_ready_o, 1'b0);
    rdy_mode = 0;
    wait_drain();
    @(posedge clk_i);
    check_flag("x_issue_ready_o", x_issue_ready_o, 1'b1);

    repeat (4) @(posedge clk_i);
    if (exp_id_q.size() != 0) begin
      other_cnt++;
      $display("%0d results were still pending at the end", exp_id_q.size());
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_cop_subsystem

/* cop_subsystem.sv */
`timescale 1ns/1ns

module cop_subsystem #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Issue interface
  input  logic                x_issue_valid_i,
  output logic                x_issue_ready_o,
  input  cop_pkg::xif_instr_t x_issue_instr_i,
  input  cop_pkg::xif_data_t  x_issue_rs1_i,
  input  cop_pkg::xif_data_t  x_issue_rs2_i,
  input  cop_pkg::xif_id_t    x_issue_id_i,
  output logic                x_issue_accept_o,

  // Result interface
  output logic                x_result_valid_o,
  input  logic                x_result_ready_i,
  output cop_pkg::xif_id_t    x_result_id_o,
  output cop_pkg::xif_reg_t   x_result_rd_o,
  output cop_pkg::xif_data_t  x_result_data_o
);

  // Decoder to buffer, buffer to execution unit
  cop_op_if dec_op ();
  cop_op_if exe_op ();

  cop_issue_decoder issue_decoder_i (
    .issue_valid_i (x_issue_valid_i),
    .issue_instr_i (x_issue_instr_i),
    .issue_rs1_i   (x_issue_rs1_i),
    .issue_rs2_i   (x_issue_rs2_i),
    .issue_id_i    (x_issue_id_i),
    .issue_ready_o (x_issue_ready_o),
    .issue_accept_o(x_issue_accept_o),
    .op_push       (dec_op.push)
  );

  cop_op_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) op_fifo_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .op_push(dec_op.pop),
    .op_pop (exe_op.push)
  );

  cop_exec_unit exec_unit_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .op_pop        (exe_op.pop),
    .result_valid_o(x_result_valid_o),
    .result_ready_i(x_result_ready_i),
    .result_id_o   (x_result_id_o),
    .result_rd_o   (x_result_rd_o),
    .result_data_o (x_result_data_o)
  );

endmodule : cop_subsystem

/* cop_exec_unit.sv */
`timescale 1ns/1ns

module cop_exec_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,

  cop_op_if.pop              op_pop,

  output logic               result_valid_o,
  input  logic               result_ready_i,
  output cop_pkg::xif_id_t   result_id_o,
  output cop_pkg::xif_reg_t  result_rd_o,
  output cop_pkg::xif_data_t result_data_o
);

  localparam int unsigned STEP_W = $clog2(cop_pkg::MUL_STEPS);

  cop_pkg::exec_state_e state_q;
  cop_pkg::exec_state_e state_d;
  logic [STEP_W-1:0]    step_q;
  logic                 last_step;
  logic                 pop_fire;

  // Multiplier datapath
  cop_pkg::xif_data_t mcand_q;
  cop_pkg::xif_data_t mplier_q;
  cop_pkg::xif_data_t acc_q;
  cop_pkg::xif_data_t partial;
  cop_pkg::xif_data_t acc_sum;

  // Result registers
  cop_pkg::xif_id_t   result_id_q;
  cop_pkg::xif_reg_t  result_rd_q;
  cop_pkg::xif_data_t result_data_q;
  cop_pkg::xif_data_t alu_result;

  assign op_pop.ready = (state_q == cop_pkg::EX_IDLE);
  assign pop_fire     = op_pop.valid & op_pop.ready;
  assign last_step    = (step_q == STEP_W'(cop_pkg::MUL_STEPS - 1));

  // Single-cycle operations
  always_comb begin
    case (op_pop.op)
      cop_pkg::OP_ADD: alu_result = op_pop.rs1 + op_pop.rs2;
      cop_pkg::OP_SUB: alu_result = op_pop.rs1 - op_pop.rs2;
      cop_pkg::OP_XOR: alu_result = op_pop.rs1 ^ op_pop.rs2;
      cop_pkg::OP_AND: alu_result = op_pop.rs1 & op_pop.rs2;
      cop_pkg::OP_MIN: begin
        alu_result = ($signed(op_pop.rs1) < $signed(op_pop.rs2)) ? op_pop.rs1 : op_pop.rs2;
      end
      cop_pkg::OP_MAX: begin
        alu_result = ($signed(op_pop.rs1) > $signed(op_pop.rs2)) ? op_pop.rs1 : op_pop.rs2;
      end
      default: alu_result = '0;
    endcase
  end

  // Radix-4 partial product, two multiplier bits at a time
  always_comb begin
    case (mplier_q[1:0])
      2'b01:   partial = mcand_q;
      2'b10:   partial = mcand_q << 1;
      2'b11:   partial = mcand_q + (mcand_q << 1);
      default: partial = '0;
    endcase
  end

  assign acc_sum = acc_q + partial;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cop_pkg::EX_IDLE: begin
        if (pop_fire) begin
          state_d = (op_pop.op == cop_pkg::OP_MUL) ? cop_pkg::EX_MUL : cop_pkg::EX_RESULT;
        end
      end
      cop_pkg::EX_MUL: begin
        if (last_step) begin
          state_d = cop_pkg::EX_RESULT;
        end
      end
      cop_pkg::EX_RESULT: begin
        if (result_ready_i) begin
          state_d = cop_pkg::EX_IDLE;
        end
      end
      default: state_d = cop_pkg::EX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= cop_pkg::EX_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (pop_fire) begin
        step_q <= '0;
      end else if (state_q == cop_pkg::EX_MUL) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // Payload only moves on a pop or a multiply step, so it holds in EX_RESULT
  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      result_id_q   <= op_pop.id;
      result_rd_q   <= op_pop.rd;
      result_data_q <= alu_result;
      mcand_q       <= op_pop.rs1;
      mplier_q      <= op_pop.rs2;
      acc_q         <= '0;
    end else if (state_q == cop_pkg::EX_MUL) begin
      mcand_q  <= mcand_q << 2;
      mplier_q <= mplier_q >> 2;
      acc_q    <= acc_sum;
      if (last_step) begin
        result_data_q <= acc_sum;
      end
    end
  end

  assign result_valid_o = (state_q == cop_pkg::EX_RESULT);
  assign result_id_o    = result_id_q;
  assign result_rd_o    = result_rd_q;
  assign result_data_o  = result_data_q;

endmodule : cop_exec_unit

/* cop_op_fifo.sv */
`timescale 1ns/1ns

module cop_op_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic   clk_i,
  input  logic   rst_n_i,

  // Write side, receives from the decoder
  cop_op_if.pop  op_push,

  // Read side, sends to the execution unit
  cop_op_if.push op_pop
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // Storage
  cop_pkg::cop_op_e   op_mem  [0:FIFO_DEPTH-1];
  cop_pkg::xif_id_t   id_mem  [0:FIFO_DEPTH-1];
  cop_pkg::xif_reg_t  rd_mem  [0:FIFO_DEPTH-1];
  cop_pkg::xif_data_t rs1_mem [0:FIFO_DEPTH-1];
  cop_pkg::xif_data_t rs2_mem [0:FIFO_DEPTH-1];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push_fire;
  logic             pop_fire;

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  assign op_push.ready = ~full;
  assign op_pop.valid  = ~empty;

  assign push_fire = op_push.valid & op_push.ready;
  assign pop_fire  = op_pop.valid & op_pop.ready;

  // Head entry
  assign op_pop.op  = op_mem[rd_ptr_q];
  assign op_pop.id  = id_mem[rd_ptr_q];
  assign op_pop.rd  = rd_mem[rd_ptr_q];
  assign op_pop.rs1 = rs1_mem[rd_ptr_q];
  assign op_pop.rs2 = rs2_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      op_mem[wr_ptr_q]  <= op_push.op;
      id_mem[wr_ptr_q]  <= op_push.id;
      rd_mem[wr_ptr_q]  <= op_push.rd;
      rs1_mem[wr_ptr_q] <= op_push.rs1;
      rs2_mem[wr_ptr_q] <= op_push.rs2;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : cop_op_fifo

/* cop_issue_decoder.sv */
`timescale 1ns/1ns

module cop_issue_decoder (
  input  logic               issue_valid_i,
  input  cop_pkg::xif_instr_t issue_instr_i,
  input  cop_pkg::xif_data_t  issue_rs1_i,
  input  cop_pkg::xif_data_t  issue_rs2_i,
  input  cop_pkg::xif_id_t    issue_id_i,
  output logic               issue_ready_o,
  output logic               issue_accept_o,

  cop_op_if.push             op_push
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       opcode_ok;
  logic       funct3_ok;

  // Instruction fields
  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];

  assign opcode_ok = (opcode == cop_pkg::OPCODE_CUSTOM0);
  assign funct3_ok = (funct3 != cop_pkg::FUNCT3_RSVD);

  // Accept decision, valid whenever the core presents an instruction
  assign issue_accept_o = opcode_ok & funct3_ok;

  // Ready follows the buffer only, rejected instructions drain the same way
  assign issue_ready_o = op_push.ready;

  // Only accepted instructions enter the buffer
  assign op_push.valid = issue_valid_i & issue_accept_o;

  // funct3 encodes the operation directly
  assign op_push.op  = cop_pkg::cop_op_e'(funct3);
  assign op_push.rd  = issue_instr_i[11:7];
  assign op_push.id  = issue_id_i;
  assign op_push.rs1 = issue_rs1_i;
  assign op_push.rs2 = issue_rs2_i;

endmodule : cop_issue_decoder

/* cop_op_if.sv */
`timescale 1ns/1ns

interface cop_op_if;

  // Handshake
  logic valid;
  logic ready;

  // Decoded operation payload
  cop_pkg::cop_op_e  op;
  cop_pkg::xif_id_t  id;
  cop_pkg::xif_reg_t rd;
  cop_pkg::xif_data_t rs1;
  cop_pkg::xif_data_t rs2;

  // Sender side
  modport push (
    output valid,
    output op,
    output id,
    output rd,
    output rs1,
    output rs2,
    input  ready
  );

  // Receiver side
  modport pop (
    input  valid,
    input  op,
    input  id,
    input  rd,
    input  rs1,
    input  rs2,
    output ready
  );

endinterface : cop_op_if

/* cop_pkg.sv */
package cop_pkg;

  // Identifier tagging an issue and its matching result
  typedef logic [3:0] xif_id_t;

  // Raw instruction word as handed over by the core
  typedef logic [31:0] xif_instr_t;

  // Operand and result values
  typedef logic [31:0] xif_data_t;

  // Destination register index
  typedef logic [4:0] xif_reg_t;

  // Operation select, encoding matches funct3
  typedef enum logic [2:0] {
    OP_ADD = 3'b000,
    OP_SUB = 3'b001,
    OP_XOR = 3'b010,
    OP_AND = 3'b011,
    OP_MIN = 3'b100,
    OP_MAX = 3'b101,
    OP_MUL = 3'b110
  } cop_op_e;

  // Execution unit states
  typedef enum logic [1:0] {
    EX_IDLE   = 2'b00,
    EX_MUL    = 2'b01,
    EX_RESULT = 2'b10
  } exec_state_e;

  // custom-0 major opcode
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // funct3 value left unused by the operation set
  localparam logic [2:0] FUNCT3_RSVD = 3'b111;

  // Multiplier iterations, two multiplier bits per step
  localparam int unsigned MUL_STEPS = 16;

endpackage : cop_pkg
